// File: bench/coreStimulus.txt
# P word : program word, loaded in order from RESET_PC
# R pc reg value : expected retirement | S addr data : expected store
P 3C011234
P 34215678
P 24020010
P 00221821
P 00612023
P 00612824
P 00A43026
P 0081382A
P 0024402B
P 00044900
P 00015202
P 292B0200
P 302CFFF0
P 240D0040
P ADA10000
P ADA60004
P 8DAE0000
P 01C27821
P 8DB00004
P 26110001
P ADB10008
P 10440002
P 24120055
P 24130066
P 14EB0002
P 24140077
P 24150088
P 0C00005F
P 24160099
P 241700AA
P 241700BB
P 03F2C021
P ADB8000C
P 8DB9000C
R 00000100 01 12340000
R 00000104 01 12345678
R 00000108 02 00000010
R 0000010C 03 12345688
R 00000110 04 00000010
R 00000114 05 12345608
R 00000118 06 12345618
R 0000011C 07 00000001
R 00000120 08 00000000
R 00000124 09 00000100
R 00000128 0A 00123456
R 0000012C 0B 00000001
R 00000130 0C 00005670
R 00000134 0D 00000040
R 00000140 0E 12345678
R 00000144 0F 12345688
R 00000148 10 12345618
R 0000014C 11 12345619
R 00000158 12 00000055
R 00000164 14 00000077
R 00000168 15 00000088
R 0000016C 1F 00000174
R 00000170 16 00000099
R 0000017C 18 000001C9
R 00000184 19 000001C9
S 00000040 12345678
S 00000044 12345618
S 00000048 12345619
S 0000004C 000001C9

// File: bench/mipsCore_checker.sv
`timescale 1ns/1ns

module mipsCoreChecker import cpuIsaPkg::*; (
    input logic  clk,
    input logic  arstN_i,
    input logic  instrStall_i,
    input logic  dataStall_i,
    input addr_t instrAddr_i,
    input logic  dataEn_i,
    input logic  dataWe_i,
    input logic  dbgWbValid_i
);
    logic frozen;

    assign frozen = instrStall_i | dataStall_i;

    // a frozen cycle must not retire anything
    noRetireWhileFrozen: assert property (@(posedge clk) disable iff (!arstN_i)
        frozen |-> !dbgWbValid_i)
        else $error("retirement pulse seen while a stall input is high");

    // pc is held through a freeze
    pcHoldOnFreeze: assert property (@(posedge clk) disable iff (!arstN_i)
        frozen |=> $stable(instrAddr_i))
        else $error("fetch address moved during a frozen cycle");

    quietInReset: assert property (@(posedge clk)
        !arstN_i |-> !dataEn_i && !dataWe_i && !dbgWbValid_i)
        else $error("data port or trace active during reset");

    // nothing reaches the memory stage before three edges have passed
    noEarlyAccess: assert property (@(posedge clk)
        $rose(arstN_i) |-> !dataEn_i [*3])
        else $error("data access before the first instruction could reach memory");

endmodule

bind mipsCore mipsCoreChecker u_checker (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .instrStall_i (instrStall_i),
    .dataStall_i  (dataStall_i),
    .instrAddr_i  (instrAddr_o),
    .dataEn_i     (dataEn_o),
    .dataWe_i     (dataWe_o),
    .dbgWbValid_i (dbgWbValid_o)
);

// File: bench/tbMipsCore.sv
`timescale 1ns/1ns

module tbMipsCore import cpuIsaPkg::*; ();
    localparam addr_t RESET_PC   = 32'h0000_0100;
    localparam int    IMEM_WORDS = 64;
    localparam int    DMEM_WORDS = 256;

    logic     clk;
    logic     arstN_i;
    addr_t    instrAddr_o;
    logic     instrEn_o;
    word_t    instr_i;
    logic     instrStall_i;
    logic     dataEn_o;
    logic     dataWe_o;
    addr_t    dataAddr_o;
    word_t    dataWdata_o;
    word_t    dataRdata_i;
    logic     dataStall_i;
    logic     dbgWbValid_o;
    addr_t    dbgWbPc_o;
    regAddr_t dbgWbReg_o;
    word_t    dbgWbData_o;

    word_t    imem [IMEM_WORDS];
    word_t    dmem [DMEM_WORDS];
    addr_t    fetchIdx;
    addr_t    expPc [$];
    regAddr_t expReg [$];
    word_t    expVal [$];
    addr_t    expAddr [$];
    word_t    expData [$];
    int       progWords;
    int       retCount;
    int       storeCount;
    int       cycleCount;
    int       cycleLimit;
    integer   seed;

    mipsCore #(.RESET_PC(RESET_PC)) u_mipsCore (
        .clk(clk), .arstN_i(arstN_i),
        .instrAddr_o(instrAddr_o), .instrEn_o(instrEn_o), .instr_i(instr_i),
        .instrStall_i(instrStall_i),
        .dataEn_o(dataEn_o), .dataWe_o(dataWe_o), .dataAddr_o(dataAddr_o),
        .dataWdata_o(dataWdata_o), .dataRdata_i(dataRdata_i), .dataStall_i(dataStall_i),
        .dbgWbValid_o(dbgWbValid_o), .dbgWbPc_o(dbgWbPc_o),
        .dbgWbReg_o(dbgWbReg_o), .dbgWbData_o(dbgWbData_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // both memories answer combinationally, nops past the program
    assign fetchIdx    = (instrAddr_o - RESET_PC) >> 2;
    assign instr_i     = (fetchIdx < IMEM_WORDS) ? imem[fetchIdx] : '0;
    assign dataRdata_i = dmem[dataAddr_o[9:2]];

    always @(posedge clk) begin
        if (dataEn_o && dataWe_o && !dataStall_i) begin
            dmem[dataAddr_o[9:2]] <= dataWdata_o;
        end
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic loadStimulus();
        integer      fd;
        integer      n;
        string       line;
        byte         kind;
        logic [31:0] a, b, c;
        fd = $fopen("bench/coreStimulus.txt", "r");
        assert (fd != 0) else reportFail("could not open bench/coreStimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
            case (kind)
                "P": begin
                    imem[progWords] = a;
                    progWords++;
                end
                "R": begin
                    expPc.push_back(a);
                    expReg.push_back(regAddr_t'(b));
                    expVal.push_back(c);
                end
                "S": begin
                    expAddr.push_back(a);
                    expData.push_back(b);
                end
                default: ;    // blank line
            endcase
        end
        $fclose(fd);
    endtask

    task automatic checkRetire();
        assert (retCount < expPc.size())
            else reportFail($sformatf("extra retirement at pc %h beyond the expected list",
                                      dbgWbPc_o));
        assert (dbgWbPc_o == expPc[retCount])
            else reportFail($sformatf("[ERROR] dbgWbPc_o got %h expected %h",
                                      dbgWbPc_o, expPc[retCount]));
        assert (dbgWbReg_o == expReg[retCount])
            else reportFail($sformatf("[ERROR] dbgWbReg_o got %h expected %h",
                                      dbgWbReg_o, expReg[retCount]));
        assert (dbgWbData_o == expVal[retCount])
            else reportFail($sformatf("[ERROR] dbgWbData_o got %h expected %h",
                                      dbgWbData_o, expVal[retCount]));
        retCount++;
    endtask

    task automatic checkStore();
        assert (storeCount < expAddr.size())
            else reportFail($sformatf("extra store to %h beyond the expected list",
                                      dataAddr_o));
        assert (dataAddr_o == expAddr[storeCount])
            else reportFail($sformatf("[ERROR] dataAddr_o got %h expected %h",
                                      dataAddr_o, expAddr[storeCount]));
        assert (dataWdata_o == expData[storeCount])
            else reportFail($sformatf("[ERROR] dataWdata_o got %h expected %h",
                                      dataWdata_o, expData[storeCount]));
        storeCount++;
    endtask

    // mid-cycle sampling, a store counts once on its unfrozen cycle
    always @(negedge clk) begin
        if (arstN_i) begin
            if (dbgWbValid_o) checkRetire();
            if (dataEn_o && dataWe_o && !instrStall_i && !dataStall_i) checkStore();
        end
    end

    // random stalls, roughly one cycle in four each
    always @(posedge clk) begin
        if (arstN_i) begin
            #2;
            instrStall_i = ($random(seed) & 3) == 0;
            dataStall_i  = ($random(seed) & 3) == 0;
        end
    end

    always @(posedge clk) begin
        if (arstN_i) begin
            cycleCount <= cycleCount + 1;
            assert (cycleCount < cycleLimit)
                else reportFail("timeout, expected retirements or stores did not all appear");
        end
    end

    initial begin
        seed         = 35510;
        arstN_i      = 1'b0;
        instrStall_i = 1'b0;
        dataStall_i  = 1'b0;
        progWords    = 0;
        retCount     = 0;
        storeCount   = 0;
        cycleCount   = 0;
        cycleLimit   = 1000;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = 32'hDA7A_0000 ^ word_t'(i * 4);
        loadStimulus();
        cycleLimit = 8 * progWords + 100;
        repeat (8) @(posedge clk);
        #2 arstN_i = 1'b1;
        // fetch leaves reset enabled at the reset vector
        assert (instrEn_o === 1'b1)
            else reportFail($sformatf("[ERROR] instrEn_o got %h expected %h",
                                      instrEn_o, 1'b1));
        assert (instrAddr_o == RESET_PC)
            else reportFail($sformatf("[ERROR] instrAddr_o got %h expected %h",
                                      instrAddr_o, RESET_PC));
        while (retCount < expPc.size() || storeCount < expAddr.size()) @(posedge clk);
        repeat (16) @(posedge clk);    // window for stray pulses
        $display("All checks passed");
        $finish;
    end

endmodule

// File: design/cpuIsaPkg.sv
package cpuIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regAddr_t;

    // bit positions of the instruction fields
    localparam int OPC_POS   = 26;
    localparam int RS_POS    = 21;
    localparam int RT_POS    = 16;
    localparam int RD_POS    = 11;
    localparam int SHAMT_POS = 6;
    localparam int FN_POS    = 0;
    localparam int IMM_POS   = 0;    // imm16, low half

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    localparam regAddr_t REG_RA = 5'd31;    // jal link register

endpackage

// File: design/cpuPipePkg.sv
package cpuPipePkg;

    typedef logic [3:0] aluOp_t;

    localparam aluOp_t ALU_ADD  = 4'd0;
    localparam aluOp_t ALU_SUB  = 4'd1;
    localparam aluOp_t ALU_AND  = 4'd2;
    localparam aluOp_t ALU_OR   = 4'd3;
    localparam aluOp_t ALU_XOR  = 4'd4;
    localparam aluOp_t ALU_SLT  = 4'd5;
    localparam aluOp_t ALU_SLTU = 4'd6;
    localparam aluOp_t ALU_SLL  = 4'd7;
    localparam aluOp_t ALU_SRL  = 4'd8;
    localparam aluOp_t ALU_LUI  = 4'd9;

    // conditional branch kind, compared in execute
    typedef logic [1:0] brKind_t;

    localparam brKind_t BR_NONE = 2'd0;
    localparam brKind_t BR_BEQ  = 2'd1;
    localparam brKind_t BR_BNE  = 2'd2;

    // where a decode operand comes from
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t FWD_RF  = 2'd0;
    localparam fwdSel_t FWD_EX  = 2'd1;
    localparam fwdSel_t FWD_MEM = 2'd2;
    localparam fwdSel_t FWD_WB  = 2'd3;

endpackage

// File: design/decodeStage.sv
`timescale 1ns/1ns

module decodeStage import cpuIsaPkg::*, cpuPipePkg::*; (
    input  logic       clk,
    input  logic       arstN_i,
    hazardCtrlIf.stage ctrl,
    input  addr_t      fetchPc_i,
    input  word_t      fetchInstr_i,
    input  word_t      exResult_i,
    input  word_t      memResult_i,
    input  word_t      wbResult_i,
    input  logic       wbWrite_i,
    input  regAddr_t   wbReg_i,
    output regAddr_t   rsAddr_o,
    output regAddr_t   rtAddr_o,
    output logic       jumpTaken_o,
    output addr_t      jumpTarget_o,
    decExIf.dec        out
);
    logic       decValid;
    addr_t      decPc;
    word_t      decInstr;
    word_t      regFile [32];
    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rd;
    word_t      rsRf, rtRf;
    word_t      rsVal, rtVal;
    word_t      extImm;
    addr_t      pcPlus4;
    logic       signExt;
    logic       isJump;
    logic       isLink;

    function automatic word_t fwdPick(fwdSel_t sel, word_t rfVal, word_t exVal,
                                      word_t memVal, word_t wbVal);
        case (sel)
            FWD_EX:  return exVal;
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return rfVal;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            decValid <= 1'b0;
        end else if (!ctrl.freeze && !ctrl.stallDecode) begin
            decValid <= !ctrl.flushDecode;   // wrong-path slot after a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.freeze && !ctrl.stallDecode) begin
            decPc    <= fetchPc_i;
            decInstr <= fetchInstr_i;
        end
    end

    // register file, memWbStage never asks to write r0
    always_ff @(posedge clk) begin
        if (wbWrite_i) begin
            regFile[wbReg_i] <= wbResult_i;
        end
    end

    assign opcode   = decInstr[OPC_POS +: 6];
    assign funct    = decInstr[FN_POS +: 6];
    assign rsAddr_o = decInstr[RS_POS +: 5];
    assign rtAddr_o = decInstr[RT_POS +: 5];
    assign rd       = decInstr[RD_POS +: 5];
    assign pcPlus4  = decPc + 32'd4;

    always_comb begin
        out.aluOp    = ALU_ADD;
        out.useImm   = 1'b1;
        out.destReg  = rtAddr_o;     // i-type writes rt
        out.regWrite = 1'b0;
        out.memRead  = 1'b0;
        out.memWrite = 1'b0;
        out.brKind   = BR_NONE;
        signExt      = 1'b1;
        isJump       = 1'b0;
        isLink       = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                out.useImm   = 1'b0;
                out.destReg  = rd;
                out.regWrite = 1'b1;
                case (funct)
                    FN_SLL:  out.aluOp = ALU_SLL;
                    FN_SRL:  out.aluOp = ALU_SRL;
                    FN_ADDU: out.aluOp = ALU_ADD;
                    FN_SUBU: out.aluOp = ALU_SUB;
                    FN_AND:  out.aluOp = ALU_AND;
                    FN_OR:   out.aluOp = ALU_OR;
                    FN_XOR:  out.aluOp = ALU_XOR;
                    FN_SLT:  out.aluOp = ALU_SLT;
                    FN_SLTU: out.aluOp = ALU_SLTU;
                    default: out.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: out.regWrite = 1'b1;
            OP_SLTI: begin
                out.aluOp    = ALU_SLT;
                out.regWrite = 1'b1;
            end
            OP_ANDI: begin
                out.aluOp    = ALU_AND;
                out.regWrite = 1'b1;
                signExt      = 1'b0;
            end
            OP_ORI: begin
                out.aluOp    = ALU_OR;
                out.regWrite = 1'b1;
                signExt      = 1'b0;
            end
            OP_LUI: begin
                out.aluOp    = ALU_LUI;
                out.regWrite = 1'b1;
            end
            OP_LW: begin
                out.memRead  = 1'b1;
                out.regWrite = 1'b1;
            end
            OP_SW:  out.memWrite = 1'b1;
            OP_BEQ: out.brKind   = BR_BEQ;
            OP_BNE: out.brKind   = BR_BNE;
            OP_J:   isJump       = 1'b1;
            OP_JAL: begin
                isJump       = 1'b1;
                isLink       = 1'b1;
                out.regWrite = 1'b1;
                out.destReg  = REG_RA;
            end
            default: ;    // unknown opcode, no-op
        endcase
    end

    // a same-cycle writeback arrives through the wb forward
    assign rsRf = (rsAddr_o == '0) ? '0 : regFile[rsAddr_o];
    assign rtRf = (rtAddr_o == '0) ? '0 : regFile[rtAddr_o];

    assign rsVal  = fwdPick(ctrl.fwdA, rsRf, exResult_i, memResult_i, wbResult_i);
    assign rtVal  = fwdPick(ctrl.fwdB, rtRf, exResult_i, memResult_i, wbResult_i);
    assign extImm = signExt ? {{16{decInstr[IMM_POS + 15]}}, decInstr[IMM_POS +: 16]} :
                              {16'h0, decInstr[IMM_POS +: 16]};

    assign out.valid        = decValid;
    assign out.pc           = decPc;
    assign out.opA          = isLink ? decPc + 32'd8 : rsVal;   // jal link via alu add
    assign out.opB          = rtVal;
    assign out.imm          = isLink ? '0 : extImm;
    assign out.shamt        = decInstr[SHAMT_POS +: 5];
    assign out.storeData    = rtVal;
    assign out.branchTarget = pcPlus4 + {extImm[29:0], 2'b00};

    assign jumpTaken_o  = decValid & isJump;
    assign jumpTarget_o = {pcPlus4[31:28], decInstr[25:0], 2'b00};

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ns

module executeStage import cpuIsaPkg::*, cpuPipePkg::*; (
    input  logic       clk,
    input  logic       arstN_i,
    hazardCtrlIf.stage ctrl,
    decExIf.ex         in,
    exMemIf.ex         out,
    output word_t      exResult_o,
    output regAddr_t   exDestReg_o,
    output logic       exRegWrite_o,
    output logic       exIsLoad_o,
    output logic       branchTaken_o,
    output addr_t      branchTarget_o
);
    logic       exValid;
    addr_t      exPc;
    addr_t      exBrTarget;
    word_t      exOpA, exOpB, exImm, exStore;
    word_t      aluB;
    word_t      aluRes;
    logic [4:0] exShamt;
    aluOp_t     exAluOp;
    logic       exUseImm;
    logic       exRegWrite;
    logic       exMemRead;
    logic       exMemWrite;
    regAddr_t   exDest;
    brKind_t    exBrKind;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            exValid <= 1'b0;
        end else if (!ctrl.freeze) begin
            exValid <= in.valid && !ctrl.flushExecute;   // load-use bubble
        end
    end

    // controls below only count while exValid is set
    always_ff @(posedge clk) begin
        if (!ctrl.freeze) begin
            exPc       <= in.pc;
            exOpA      <= in.opA;
            exOpB      <= in.opB;
            exImm      <= in.imm;
            exShamt    <= in.shamt;
            exAluOp    <= in.aluOp;
            exUseImm   <= in.useImm;
            exDest     <= in.destReg;
            exRegWrite <= in.regWrite;
            exMemRead  <= in.memRead;
            exMemWrite <= in.memWrite;
            exStore    <= in.storeData;
            exBrKind   <= in.brKind;
            exBrTarget <= in.branchTarget;
        end
    end

    assign aluB = exUseImm ? exImm : exOpB;

    always_comb begin
        case (exAluOp)
            ALU_ADD:  aluRes = exOpA + aluB;
            ALU_SUB:  aluRes = exOpA - aluB;
            ALU_AND:  aluRes = exOpA & aluB;
            ALU_OR:   aluRes = exOpA | aluB;
            ALU_XOR:  aluRes = exOpA ^ aluB;
            ALU_SLT:  aluRes = {31'b0, $signed(exOpA) < $signed(aluB)};
            ALU_SLTU: aluRes = {31'b0, exOpA < aluB};
            ALU_SLL:  aluRes = exOpB << exShamt;    // shifts act on rt
            ALU_SRL:  aluRes = exOpB >> exShamt;
            ALU_LUI:  aluRes = {aluB[15:0], 16'h0};
            default:  aluRes = '0;
        endcase
    end

    always_comb begin
        case (exBrKind)
            BR_BEQ:  branchTaken_o = exValid && (exOpA == exOpB);
            BR_BNE:  branchTaken_o = exValid && (exOpA != exOpB);
            default: branchTaken_o = 1'b0;
        endcase
    end

    assign branchTarget_o = exBrTarget;
    assign exResult_o     = aluRes;
    assign exDestReg_o    = exDest;
    assign exRegWrite_o   = exValid & exRegWrite;
    assign exIsLoad_o     = exValid & exMemRead;

    assign out.valid     = exValid;
    assign out.pc        = exPc;
    assign out.result    = aluRes;
    assign out.storeData = exStore;
    assign out.destReg   = exDest;
    assign out.regWrite  = exRegWrite;
    assign out.memRead   = exMemRead;
    assign out.memWrite  = exMemWrite;

endmodule

// File: design/fetchStage.sv
`timescale 1ns/1ns

module fetchStage import cpuIsaPkg::*; #(
    parameter addr_t RESET_PC = 32'hBFC0_0000
) (
    input  logic       clk,
    input  logic       arstN_i,
    hazardCtrlIf.stage ctrl,
    input  logic       branchTaken_i,
    input  addr_t      branchTarget_i,
    input  logic       jumpTaken_i,
    input  addr_t      jumpTarget_i,
    output addr_t      instrAddr_o,
    output logic       instrEn_o,
    input  word_t      instr_i,
    output addr_t      fetchPc_o,
    output word_t      fetchInstr_o
);
    addr_t pc;
    addr_t nextPc;

    // a taken branch in execute wins over a jump sitting in its delay slot
    assign nextPc = branchTaken_i ? branchTarget_i :
                    jumpTaken_i   ? jumpTarget_i   : pc + 32'd4;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pc <= RESET_PC;
        end else if (!ctrl.freeze && !ctrl.stallFetch) begin
            pc <= nextPc;
        end
    end

    assign instrAddr_o  = pc;
    assign instrEn_o    = ~ctrl.stallDecode;   // no new fetch while decode holds
    assign fetchPc_o    = pc;
    assign fetchInstr_o = instr_i;

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit import cpuIsaPkg::*, cpuPipePkg::*; (
    input  logic      instrStall_i,
    input  logic      dataStall_i,
    input  regAddr_t  rsAddr_i,
    input  regAddr_t  rtAddr_i,
    input  regAddr_t  exDestReg_i,
    input  logic      exRegWrite_i,
    input  logic      exIsLoad_i,
    input  regAddr_t  memDestReg_i,
    input  logic      memRegWrite_i,
    input  regAddr_t  wbReg_i,
    input  logic      wbWrite_i,
    input  logic      branchTaken_i,
    hazardCtrlIf.ctrl ctrl
);
    logic loadUse;

    // youngest producer wins, r0 always reads the file
    function automatic fwdSel_t pickSrc(regAddr_t src);
        if (src == '0) return FWD_RF;
        if (exRegWrite_i && exDestReg_i == src) return FWD_EX;
        if (memRegWrite_i && memDestReg_i == src) return FWD_MEM;
        if (wbWrite_i && wbReg_i == src) return FWD_WB;
        return FWD_RF;
    endfunction

    always_comb begin
        ctrl.fwdA = pickSrc(rsAddr_i);
        ctrl.fwdB = pickSrc(rtAddr_i);
    end

    // load result not there until the memory cycle
    assign loadUse = exIsLoad_i && (exDestReg_i != '0) &&
                     (exDestReg_i == rsAddr_i || exDestReg_i == rtAddr_i);

    assign ctrl.freeze       = instrStall_i | dataStall_i;
    assign ctrl.stallFetch   = loadUse;
    assign ctrl.stallDecode  = loadUse;
    assign ctrl.flushExecute = loadUse;
    assign ctrl.flushDecode  = branchTaken_i;   // drop the instruction behind the delay slot

endmodule

// File: design/memWbStage.sv
`timescale 1ns/1ns

module memWbStage import cpuIsaPkg::*; (
    input  logic       clk,
    input  logic       arstN_i,
    hazardCtrlIf.stage ctrl,
    exMemIf.mem        in,
    output logic       dataEn_o,
    output logic       dataWe_o,
    output addr_t      dataAddr_o,
    output word_t      dataWdata_o,
    input  word_t      dataRdata_i,
    output word_t      memResult_o,
    output regAddr_t   memDestReg_o,
    output logic       memRegWrite_o,
    output word_t      wbResult_o,
    output regAddr_t   wbReg_o,
    output logic       wbWrite_o,
    output logic       dbgWbValid_o,
    output addr_t      dbgWbPc_o
);
    logic     memValid, memRegWrite, memRead, memWrite;
    addr_t    memPc;
    word_t    memAlu;
    word_t    memStore;
    regAddr_t memDest;
    logic     wbValid, wbRegWrite;
    addr_t    wbPc;
    word_t    wbData;
    regAddr_t wbDest;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            memValid <= 1'b0;
            wbValid  <= 1'b0;
        end else if (!ctrl.freeze) begin
            memValid <= in.valid;
            wbValid  <= memValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.freeze) begin
            memPc       <= in.pc;
            memAlu      <= in.result;
            memStore    <= in.storeData;
            memDest     <= in.destReg;
            memRegWrite <= in.regWrite;
            memRead     <= in.memRead;
            memWrite    <= in.memWrite;
            wbPc        <= memPc;
            wbData      <= memResult_o;
            wbDest      <= memDest;
            wbRegWrite  <= memRegWrite;
        end
    end

    // data port, read data comes back in the same cycle
    assign dataEn_o      = memValid & (memRead | memWrite);
    assign dataWe_o      = memValid & memWrite;
    assign dataAddr_o    = memAlu;
    assign dataWdata_o   = memStore;
    assign memResult_o   = memRead ? dataRdata_i : memAlu;
    assign memDestReg_o  = memDest;
    assign memRegWrite_o = memValid & memRegWrite;

    assign wbWrite_o    = wbValid & wbRegWrite & (wbDest != '0);
    assign wbResult_o   = wbData;
    assign wbReg_o      = wbDest;
    assign dbgWbValid_o = wbWrite_o & ~ctrl.freeze;   // one pulse per retirement
    assign dbgWbPc_o    = wbPc;

endmodule

// File: design/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import cpuIsaPkg::*; #(
    parameter addr_t RESET_PC = 32'hBFC0_0000
) (
    input  logic     clk,
    input  logic     arstN_i,
    output addr_t    instrAddr_o,
    output logic     instrEn_o,
    input  word_t    instr_i,
    input  logic     instrStall_i,
    output logic     dataEn_o,
    output logic     dataWe_o,
    output addr_t    dataAddr_o,
    output word_t    dataWdata_o,
    input  word_t    dataRdata_i,
    input  logic     dataStall_i,
    output logic     dbgWbValid_o,
    output addr_t    dbgWbPc_o,
    output regAddr_t dbgWbReg_o,
    output word_t    dbgWbData_o
);
    decExIf      decEx ();
    exMemIf      exMem ();
    hazardCtrlIf hzd ();

    addr_t    fetchPc, branchTarget, jumpTarget;
    word_t    fetchInstr, exResult, memResult, wbResult;
    logic     branchTaken, jumpTaken;
    logic     exRegWrite, exIsLoad, memRegWrite, wbWrite;
    regAddr_t rsAddr, rtAddr, exDestReg, memDestReg, wbReg;

    assign dbgWbReg_o  = wbReg;
    assign dbgWbData_o = wbResult;

    fetchStage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .arstN_i(arstN_i), .ctrl(hzd.stage),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .jumpTaken_i(jumpTaken), .jumpTarget_i(jumpTarget),
        .instrAddr_o(instrAddr_o), .instrEn_o(instrEn_o), .instr_i(instr_i),
        .fetchPc_o(fetchPc), .fetchInstr_o(fetchInstr)
    );

    decodeStage u_decode (
        .clk(clk), .arstN_i(arstN_i), .ctrl(hzd.stage),
        .fetchPc_i(fetchPc), .fetchInstr_i(fetchInstr),
        .exResult_i(exResult), .memResult_i(memResult), .wbResult_i(wbResult),
        .wbWrite_i(wbWrite), .wbReg_i(wbReg),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr),
        .jumpTaken_o(jumpTaken), .jumpTarget_o(jumpTarget), .out(decEx.dec)
    );

    executeStage u_execute (
        .clk(clk), .arstN_i(arstN_i), .ctrl(hzd.stage),
        .in(decEx.ex), .out(exMem.ex),
        .exResult_o(exResult), .exDestReg_o(exDestReg),
        .exRegWrite_o(exRegWrite), .exIsLoad_o(exIsLoad),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget)
    );

    memWbStage u_memWb (
        .clk(clk), .arstN_i(arstN_i), .ctrl(hzd.stage), .in(exMem.mem),
        .dataEn_o(dataEn_o), .dataWe_o(dataWe_o), .dataAddr_o(dataAddr_o),
        .dataWdata_o(dataWdata_o), .dataRdata_i(dataRdata_i),
        .memResult_o(memResult), .memDestReg_o(memDestReg), .memRegWrite_o(memRegWrite),
        .wbResult_o(wbResult), .wbReg_o(wbReg), .wbWrite_o(wbWrite),
        .dbgWbValid_o(dbgWbValid_o), .dbgWbPc_o(dbgWbPc_o)
    );

    hazardUnit u_hazard (
        .instrStall_i(instrStall_i), .dataStall_i(dataStall_i),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr),
        .exDestReg_i(exDestReg), .exRegWrite_i(exRegWrite), .exIsLoad_i(exIsLoad),
        .memDestReg_i(memDestReg), .memRegWrite_i(memRegWrite),
        .wbReg_i(wbReg), .wbWrite_i(wbWrite),
        .branchTaken_i(branchTaken), .ctrl(hzd.ctrl)
    );

endmodule

// File: design/pipeIf.sv
`timescale 1ns/1ns

// decode to execute bundle, valid for the instruction now in decode
interface decExIf import cpuIsaPkg::*, cpuPipePkg::*; ();
    logic       valid;
    addr_t      pc;
    word_t      opA;
    word_t      opB;
    word_t      imm;
    logic [4:0] shamt;
    aluOp_t     aluOp;
    logic       useImm;
    regAddr_t   destReg;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    word_t      storeData;
    brKind_t    brKind;
    addr_t      branchTarget;

    modport dec (output valid, pc, opA, opB, imm, shamt, aluOp, useImm, destReg, regWrite,
                 memRead, memWrite, storeData, brKind, branchTarget);
    modport ex  (input valid, pc, opA, opB, imm, shamt, aluOp, useImm, destReg, regWrite,
                 memRead, memWrite, storeData, brKind, branchTarget);
endinterface

interface exMemIf import cpuIsaPkg::*; ();
    logic     valid;
    addr_t    pc;
    word_t    result;     // alu result, also the data address
    word_t    storeData;
    regAddr_t destReg;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;

    modport ex  (output valid, pc, result, storeData, destReg, regWrite, memRead, memWrite);
    modport mem (input valid, pc, result, storeData, destReg, regWrite, memRead, memWrite);
endinterface

interface hazardCtrlIf import cpuPipePkg::*; ();
    logic    stallFetch;
    logic    stallDecode;
    logic    freeze;          // external stall, whole pipe holds
    logic    flushDecode;
    logic    flushExecute;
    fwdSel_t fwdA;
    fwdSel_t fwdB;

    modport ctrl  (output stallFetch, stallDecode, freeze, flushDecode, flushExecute, fwdA, fwdB);
    modport stage (input stallFetch, stallDecode, freeze, flushDecode, flushExecute, fwdA, fwdB);
endinterface

// File: files.f
design/cpuIsaPkg.sv
design/cpuPipePkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/hazardUnit.sv
design/mipsCore.sv
bench/mipsCore_checker.sv
bench/tbMipsCore.sv
